// File: list.f
+incdir+test
verilog/id_pkg.sv
verilog/instr_decoder.sv
verilog/imm_gen.sv
verilog/operand_select.sv
verilog/id_ex_reg.sv
verilog/id_stage.sv
test/id_stage_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --assert --top-module id_stage_tb -f list.f \
  --Mdir "$build_dir" -o id_stage_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/id_stage_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

# The log decides pass or fail
if grep -q "test failed" "$log_file"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi
exit 0

// File: test/id_stage_vectors.svh
/*
 * Decode stage vector table
 * One add_row call per cycle. Bus data set by set_bus_data holds
 * for the rows that follow it
 */
`ifndef ID_STAGE_VECTORS_SVH
`define ID_STAGE_VECTORS_SVH

// Row columns, one line each
//   name, instr, pc, fw_a, fw_b, ctrl {instr_valid, deassert_we, kill, halt, ex_ready}
//   id_ready, ctrl_xfer, jmp_target (JAL and JALR rows only)
//   flags {valid, rf_we, lsu_en, lsu_we, sign_ext, branch, illegal}, alu_op, lsu_size,
//   operand a, operand b, operand c, rd
task automatic load_vectors();
  // rs1, rs2, EX and WB data
  set_bus_data('h11, 'h22, 'h1000, 'h44);

  // Register and immediate ALU ops
  add_row("add", 'h002081b3, 'h100, id_pkg::FW_RF, id_pkg::FW_RF, 5'b10001,
          1'b1, id_pkg::XFER_NONE, 'h0,
          7'b1100000, id_pkg::ALU_ADD, id_pkg::LSU_BYTE, 'h11, 'h22, 'h0, 5'd3);
  add_row("sub_fw", 'h402081b3, 'h100, id_pkg::FW_EX, id_pkg::FW_WB, 5'b10001,
          1'b1, id_pkg::XFER_NONE, 'h0,
          7'b1100000, id_pkg::ALU_SUB, id_pkg::LSU_BYTE, 'h1000, 'h44, 'h0, 5'd3);
  add_row("sltiu", 'hfff0b213, 'h104, id_pkg::FW_RF, id_pkg::FW_RF, 5'b10001,
          1'b1, id_pkg::XFER_NONE, 'h0,
          7'b1100000, id_pkg::ALU_SLTU, id_pkg::LSU_BYTE, 'h11, 'hffffffff, 'h0, 5'd4);
  add_row("srai", 'h4030d213, 'h108, id_pkg::FW_RF, id_pkg::FW_RF, 5'b10001,
          1'b1, id_pkg::XFER_NONE, 'h0,
          7'b1100000, id_pkg::ALU_SRA, id_pkg::LSU_BYTE, 'h11, 'h403, 'h0, 5'd4);

  // Upper immediates, loads and stores
  add_row("lui", 'habcde337, 'h10c, id_pkg::FW_RF, id_pkg::FW_RF, 5'b10001,
          1'b1, id_pkg::XFER_NONE, 'h0,
          7'b1100000, id_pkg::ALU_ADD, id_pkg::LSU_BYTE, 'h0, 'habcde000, 'h0, 5'd6);
  add_row("auipc", 'h12345397, 'h200, id_pkg::FW_RF, id_pkg::FW_RF, 5'b10001,
          1'b1, id_pkg::XFER_NONE, 'h0,
          7'b1100000, id_pkg::ALU_ADD, id_pkg::LSU_BYTE, 'h200, 'h12345000, 'h0, 5'd7);
  add_row("lh", 'hffc09403, 'h204, id_pkg::FW_RF, id_pkg::FW_RF, 5'b10001,
          1'b1, id_pkg::XFER_NONE, 'h0,
          7'b1110100, id_pkg::ALU_ADD, id_pkg::LSU_HALF, 'h11, 'hfffffffc, 'h0, 5'd8);
  add_row("lbu_fw_wb", 'h0080c483, 'h208, id_pkg::FW_WB, id_pkg::FW_RF, 5'b10001,
          1'b1, id_pkg::XFER_NONE, 'h0,
          7'b1110000, id_pkg::ALU_ADD, id_pkg::LSU_BYTE, 'h44, 'h8, 'h0, 5'd9);
  add_row("sw_fw_ex", 'h0020aa23, 'h20c, id_pkg::FW_RF, id_pkg::FW_EX, 5'b10001,
          1'b1, id_pkg::XFER_NONE, 'h0,
          7'b1011000, id_pkg::ALU_ADD, id_pkg::LSU_WORD, 'h11, 'h14, 'h1000, 5'd0);

  // Jumps link PC + 4, branch target rides on operand C
  add_row("jal", 'h010000ef, 'h300, id_pkg::FW_RF, id_pkg::FW_RF, 5'b10001,
          1'b1, id_pkg::XFER_JAL, 'h310,
          7'b1100000, id_pkg::ALU_ADD, id_pkg::LSU_BYTE, 'h300, 'h4, 'h0, 5'd1);
  add_row("jalr_fw", 'h005080e7, 'h400, id_pkg::FW_EX, id_pkg::FW_RF, 5'b10001,
          1'b1, id_pkg::XFER_JALR, 'h1004,
          7'b1100000, id_pkg::ALU_ADD, id_pkg::LSU_BYTE, 'h400, 'h4, 'h0, 5'd1);
  add_row("bne", 'hfe209ce3, 'h500, id_pkg::FW_RF, id_pkg::FW_RF, 5'b10001,
          1'b1, id_pkg::XFER_BRANCH, 'h0,
          7'b1000010, id_pkg::ALU_NE, id_pkg::LSU_BYTE, 'h11, 'h22, 'h4f8, 5'd0);

  // Illegal encodings and squashed write enables
  add_row("bad_opcode", 'h0000007f, 'h600, id_pkg::FW_RF, id_pkg::FW_RF, 5'b10001,
          1'b1, id_pkg::XFER_NONE, 'h0,
          7'b1000001, id_pkg::ALU_ADD, id_pkg::LSU_BYTE, 'h11, 'h22, 'h0, 5'd0);
  add_row("bad_funct7", 'h022081b3, 'h604, id_pkg::FW_RF, id_pkg::FW_RF, 5'b10001,
          1'b1, id_pkg::XFER_NONE, 'h0,
          7'b1000001, id_pkg::ALU_ADD, id_pkg::LSU_BYTE, 'h11, 'h22, 'h0, 5'd0);
  add_row("deassert_sw", 'h0020aa23, 'h608, id_pkg::FW_RF, id_pkg::FW_RF, 5'b11001,
          1'b1, id_pkg::XFER_NONE, 'h0,
          7'b1000000, id_pkg::ALU_ADD, id_pkg::LSU_BYTE, 'h11, 'h14, 'h22, 5'd0);

  // New data so a wrong capture shows up while stalled
  set_bus_data('h55, 'h66, 'h1000, 'h44);
  add_row("stall", 'h002081b3, 'h700, id_pkg::FW_RF, id_pkg::FW_RF, 5'b10000,
          1'b0, id_pkg::XFER_NONE, 'h0,
          7'b1000000, id_pkg::ALU_ADD, id_pkg::LSU_BYTE, 'h11, 'h14, 'h22, 5'd0);
  add_row("halt", 'h002081b3, 'h704, id_pkg::FW_RF, id_pkg::FW_RF, 5'b10011,
          1'b0, id_pkg::XFER_NONE, 'h0,
          7'b0000000, id_pkg::ALU_ADD, id_pkg::LSU_BYTE, 'h11, 'h14, 'h22, 5'd0);
  add_row("kill", 'h002081b3, 'h708, id_pkg::FW_RF, id_pkg::FW_RF, 5'b10101,
          1'b1, id_pkg::XFER_NONE, 'h0,
          7'b0000000, id_pkg::ALU_ADD, id_pkg::LSU_BYTE, 'h11, 'h14, 'h22, 5'd0);
  add_row("resume", 'h002081b3, 'h70c, id_pkg::FW_RF, id_pkg::FW_RF, 5'b10001,
          1'b1, id_pkg::XFER_NONE, 'h0,
          7'b1100000, id_pkg::ALU_ADD, id_pkg::LSU_BYTE, 'h55, 'h66, 'h0, 5'd3);
  add_row("bubble", 'h002081b3, 'h710, id_pkg::FW_RF, id_pkg::FW_RF, 5'b00001,
          1'b1, id_pkg::XFER_NONE, 'h0,
          7'b0100000, id_pkg::ALU_ADD, id_pkg::LSU_BYTE, 'h55, 'h66, 'h0, 5'd3);
endtask

`endif

// File: test/id_stage_tb.sv
/*
 * Testbench for the RV32I decode stage
 * Applies the vector table one row per cycle, checks the same-cycle
 * outputs before the clock edge and the ID/EX register after it
 */
`timescale 1ns/1ps

module id_stage_tb;

  typedef struct packed {
    logic [31:0]        instr;
    logic [31:0]        pc;
    logic [31:0]        rs1_data;
    logic [31:0]        rs2_data;
    logic [31:0]        ex_data;
    logic [31:0]        wb_data;
    id_pkg::fw_sel_e    fw_a;
    id_pkg::fw_sel_e    fw_b;
    logic [4:0]         ctrl;
    logic               exp_ready;
    id_pkg::ctrl_xfer_e exp_xfer;
    logic [31:0]        exp_jmp;
    logic [6:0]         exp_flags;
    id_pkg::alu_op_e    exp_alu;
    id_pkg::lsu_size_e  exp_size;
    logic [31:0]        exp_a;
    logic [31:0]        exp_b;
    logic [31:0]        exp_c;
    logic [4:0]         exp_rd;
  } vector_t;

  logic clk;
  logic rst_n;
  logic [31:0] instr_i, pc_i, rs1_rdata_i, rs2_rdata_i, ex_wdata_i, wb_wdata_i;
  logic instr_valid_i, deassert_we_i, kill_i, halt_i, ex_ready_i;
  id_pkg::fw_sel_e fw_a_sel_i, fw_b_sel_i;
  logic [4:0] rs1_addr_o, rs2_addr_o, ex_rd_addr_o;
  logic [31:0] jmp_target_o, ex_operand_a_o, ex_operand_b_o, ex_operand_c_o, ex_pc_o;
  id_pkg::ctrl_xfer_e ctrl_xfer_o;
  id_pkg::alu_op_e ex_alu_op_o;
  id_pkg::lsu_size_e ex_lsu_size_o;
  logic id_ready_o, ex_valid_o, ex_rf_we_o, ex_lsu_en_o, ex_lsu_we_o;
  logic ex_lsu_sign_ext_o, ex_branch_o, ex_illegal_o;

  vector_t vectors[$];
  string names[$];
  string test_name;
  logic [31:0] cur_rs1, cur_rs2, cur_ex, cur_wb;
  int cycle_count = 0;
  int cycle_limit = 0;

  id_stage id_stage_i (.*);

  ////////////////////
  // Table building
  ////////////////////

  task automatic set_bus_data(input logic [31:0] rs1, rs2, ex, wb);
    cur_rs1 = rs1;
    cur_rs2 = rs2;
    cur_ex  = ex;
    cur_wb  = wb;
  endtask

  task automatic add_row(input string name, input logic [31:0] instr, input logic [31:0] pc,
                         input id_pkg::fw_sel_e fw_a, input id_pkg::fw_sel_e fw_b,
                         input logic [4:0] ctrl, input logic rdy,
                         input id_pkg::ctrl_xfer_e xfer, input logic [31:0] jmp,
                         input logic [6:0] flags, input id_pkg::alu_op_e alu,
                         input id_pkg::lsu_size_e size, input logic [31:0] op_a,
                         input logic [31:0] op_b, input logic [31:0] op_c,
                         input logic [4:0] rd);
    vector_t v;
    v = '{instr, pc, cur_rs1, cur_rs2, cur_ex, cur_wb, fw_a, fw_b, ctrl, rdy, xfer, jmp,
          flags, alu, size, op_a, op_b, op_c, rd};
    vectors.push_back(v);
    names.push_back(name);
  endtask

  `include "id_stage_vectors.svh"

  ////////////////////
  // Checking
  ////////////////////

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("test failed");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_value(input string field, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      fail_run($sformatf("Error: %s %s expected 0x%08h actual 0x%08h",
                         test_name, field, exp, act));
    end
  endtask

  task automatic check_reset_state();
    test_name = "reset";
    check_value("ex_valid", 0, 32'(ex_valid_o));
    check_value("ex_rf_we", 0, 32'(ex_rf_we_o));
    check_value("ex_lsu_en", 0, 32'(ex_lsu_en_o));
    check_value("ex_illegal", 0, 32'(ex_illegal_o));
    check_value("ex_alu_op", 32'(id_pkg::ALU_ADD), 32'(ex_alu_op_o));
    check_value("ex_operand_a", 0, ex_operand_a_o);
    check_value("ex_operand_b", 0, ex_operand_b_o);
    check_value("ex_operand_c", 0, ex_operand_c_o);
  endtask

  // Same-cycle outputs, sampled just before the edge
  task automatic check_comb(input int idx);
    vector_t v;
    v = vectors[idx];
    test_name = names[idx];
    check_value("id_ready", 32'(v.exp_ready), 32'(id_ready_o));
    check_value("ctrl_xfer", 32'(v.exp_xfer), 32'(ctrl_xfer_o));
    check_value("rs1_addr", 32'(v.instr[19:15]), 32'(rs1_addr_o));
    check_value("rs2_addr", 32'(v.instr[24:20]), 32'(rs2_addr_o));
    if (v.exp_xfer == id_pkg::XFER_JAL || v.exp_xfer == id_pkg::XFER_JALR) begin
      check_value("jmp_target", v.exp_jmp, jmp_target_o);
    end
  endtask

  // ID/EX contents one edge after the row was driven
  task automatic check_ex_reg(input int idx);
    vector_t v;
    v = vectors[idx];
    test_name = names[idx];
    check_value("ex_valid", 32'(v.exp_flags[6]), 32'(ex_valid_o));
    check_value("ex_rf_we", 32'(v.exp_flags[5]), 32'(ex_rf_we_o));
    check_value("ex_lsu_en", 32'(v.exp_flags[4]), 32'(ex_lsu_en_o));
    check_value("ex_branch", 32'(v.exp_flags[1]), 32'(ex_branch_o));
    check_value("ex_illegal", 32'(v.exp_flags[0]), 32'(ex_illegal_o));
    check_value("ex_alu_op", 32'(v.exp_alu), 32'(ex_alu_op_o));
    check_value("ex_operand_a", v.exp_a, ex_operand_a_o);
    check_value("ex_operand_b", v.exp_b, ex_operand_b_o);
    check_value("ex_operand_c", v.exp_c, ex_operand_c_o);
    // rd and LSU fields only load with their enable
    if (v.exp_flags[5]) begin
      check_value("ex_rd_addr", 32'(v.exp_rd), 32'(ex_rd_addr_o));
    end
    if (v.exp_flags[4]) begin
      check_value("ex_lsu_we", 32'(v.exp_flags[3]), 32'(ex_lsu_we_o));
      check_value("ex_lsu_sign_ext", 32'(v.exp_flags[2]), 32'(ex_lsu_sign_ext_o));
      check_value("ex_lsu_size", 32'(v.exp_size), 32'(ex_lsu_size_o));
    end
    // Accepted means valid, no kill, no halt and EX ready
    if (v.ctrl[4] && !v.ctrl[2] && !v.ctrl[1] && v.ctrl[0]) begin
      check_value("ex_pc", v.pc, ex_pc_o);
    end
  endtask

  task automatic drive_row(input vector_t v);
    instr_i     = v.instr;
    pc_i        = v.pc;
    rs1_rdata_i = v.rs1_data;
    rs2_rdata_i = v.rs2_data;
    ex_wdata_i  = v.ex_data;
    wb_wdata_i  = v.wb_data;
    fw_a_sel_i  = v.fw_a;
    fw_b_sel_i  = v.fw_b;
    {instr_valid_i, deassert_we_i, kill_i, halt_i, ex_ready_i} = v.ctrl;
  endtask

  ////////////////////
  // Clock, timeout and sequence
  ////////////////////

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      fail_run("Timeout, the vector table did not finish within the cycle limit");
    end
  end

  initial begin : stimulus
    int idx;
    rst_n         = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    instr_valid_i = 1'b0;
    deassert_we_i = 1'b0;
    kill_i        = 1'b0;
    halt_i        = 1'b0;
    ex_ready_i    = 1'b0;
    fw_a_sel_i    = id_pkg::FW_RF;
    fw_b_sel_i    = id_pkg::FW_RF;
    rs1_rdata_i   = '0;
    rs2_rdata_i   = '0;
    ex_wdata_i    = '0;
    wb_wdata_i    = '0;
    load_vectors();
    cycle_limit = vectors.size() * 4 + 40;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_reset_state();
    for (idx = 0; idx < vectors.size(); idx++) begin
      @(posedge clk);
      #1;
      if (idx > 0) begin
        check_ex_reg(idx - 1);
      end
      drive_row(vectors[idx]);
      #2;
      check_comb(idx);
    end
    @(posedge clk);
    #1;
    check_ex_reg(vectors.size() - 1);
    $display("test passed");
    $finish;
  end

endmodule

// File: verilog/id_stage.sv
/*
 * RV32I instruction decode stage
 * Decoder, immediate generator and operand path feeding the
 * ID/EX pipeline register. Register addresses, jump target and
 * transfer type leave the stage in the same cycle
 */
`timescale 1ns/1ps

module id_stage (
  input  logic                          clk,
  input  logic                          rst_n,
  // Fetch side
  input  logic [id_pkg::XLEN-1:0]       instr_i,
  input  logic [id_pkg::XLEN-1:0]       pc_i,
  input  logic                          instr_valid_i,
  // Controller
  input  id_pkg::fw_sel_e               fw_a_sel_i,
  input  id_pkg::fw_sel_e               fw_b_sel_i,
  input  logic                          deassert_we_i,
  input  logic                          kill_i,
  input  logic                          halt_i,
  // Register file
  output logic [id_pkg::REG_ADDR_W-1:0] rs1_addr_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rs2_addr_o,
  input  logic [id_pkg::XLEN-1:0]       rs1_rdata_i,
  input  logic [id_pkg::XLEN-1:0]       rs2_rdata_i,
  // Bypass data from later stages
  input  logic [id_pkg::XLEN-1:0]       ex_wdata_i,
  input  logic [id_pkg::XLEN-1:0]       wb_wdata_i,
  // Control transfer
  output logic [id_pkg::XLEN-1:0]       jmp_target_o,
  output id_pkg::ctrl_xfer_e            ctrl_xfer_o,
  // Handshake
  output logic                          id_ready_o,
  input  logic                          ex_ready_i,
  // ID/EX pipeline
  output logic                          ex_valid_o,
  output id_pkg::alu_op_e               ex_alu_op_o,
  output logic [id_pkg::XLEN-1:0]       ex_operand_a_o,
  output logic [id_pkg::XLEN-1:0]       ex_operand_b_o,
  output logic [id_pkg::XLEN-1:0]       ex_operand_c_o,
  output logic                          ex_rf_we_o,
  output logic [id_pkg::REG_ADDR_W-1:0] ex_rd_addr_o,
  output logic                          ex_lsu_en_o,
  output logic                          ex_lsu_we_o,
  output id_pkg::lsu_size_e             ex_lsu_size_o,
  output logic                          ex_lsu_sign_ext_o,
  output logic                          ex_branch_o,
  output logic                          ex_illegal_o,
  output logic [id_pkg::XLEN-1:0]       ex_pc_o
);

  // Decoder outputs
  id_pkg::alu_op_e   alu_op;
  id_pkg::op_a_sel_e op_a_sel;
  id_pkg::op_b_sel_e op_b_sel;
  id_pkg::op_c_sel_e op_c_sel;
  id_pkg::imm_sel_e  imm_sel;
  id_pkg::lsu_size_e lsu_size;
  logic              rf_we;
  logic              lsu_en;
  logic              lsu_we;
  logic              lsu_sign_ext;
  logic              illegal;

  // Immediates and operands
  logic [id_pkg::XLEN-1:0]       imm_b;
  logic [id_pkg::XLEN-1:0]       imm_i;
  logic [id_pkg::XLEN-1:0]       imm_sb;
  logic [id_pkg::XLEN-1:0]       imm_j;
  logic [id_pkg::XLEN-1:0]       imm_u;
  logic [id_pkg::XLEN-1:0]       operand_a;
  logic [id_pkg::XLEN-1:0]       operand_b;
  logic [id_pkg::XLEN-1:0]       operand_c;
  logic [id_pkg::REG_ADDR_W-1:0] rd_addr;

  // Register fields sit at fixed positions in every format
  assign rs1_addr_o = instr_i[id_pkg::RS1_LSB +: id_pkg::REG_ADDR_W];
  assign rs2_addr_o = instr_i[id_pkg::RS2_LSB +: id_pkg::REG_ADDR_W];
  assign rd_addr    = instr_i[id_pkg::RD_LSB +: id_pkg::REG_ADDR_W];

  instr_decoder instr_decoder_i (
    .instr_i(instr_i), .deassert_we_i(deassert_we_i),
    .alu_op_o(alu_op), .op_a_sel_o(op_a_sel), .op_b_sel_o(op_b_sel),
    .op_c_sel_o(op_c_sel), .imm_sel_o(imm_sel), .ctrl_xfer_o(ctrl_xfer_o),
    .rf_we_o(rf_we), .lsu_en_o(lsu_en), .lsu_we_o(lsu_we),
    .lsu_size_o(lsu_size), .lsu_sign_ext_o(lsu_sign_ext), .illegal_o(illegal)
  );

  imm_gen imm_gen_i (
    .instr_i(instr_i), .imm_sel_i(imm_sel),
    .imm_b_o(imm_b), .imm_i_o(imm_i), .imm_sb_o(imm_sb), .imm_j_o(imm_j), .imm_u_o(imm_u)
  );

  operand_select operand_select_i (
    .pc_i(pc_i), .rs1_rdata_i(rs1_rdata_i), .rs2_rdata_i(rs2_rdata_i),
    .ex_wdata_i(ex_wdata_i), .wb_wdata_i(wb_wdata_i),
    .fw_a_sel_i(fw_a_sel_i), .fw_b_sel_i(fw_b_sel_i),
    .op_a_sel_i(op_a_sel), .op_b_sel_i(op_b_sel), .op_c_sel_i(op_c_sel),
    .ctrl_xfer_i(ctrl_xfer_o),
    .imm_b_i(imm_b), .imm_i_i(imm_i), .imm_sb_i(imm_sb), .imm_j_i(imm_j), .imm_u_i(imm_u),
    .operand_a_o(operand_a), .operand_b_o(operand_b), .operand_c_o(operand_c),
    .jmp_target_o(jmp_target_o)
  );

  id_ex_reg id_ex_reg_i (
    .clk(clk), .rst_n(rst_n),
    .instr_valid_i(instr_valid_i), .kill_i(kill_i), .halt_i(halt_i), .ex_ready_i(ex_ready_i),
    .alu_op_i(alu_op), .operand_a_i(operand_a), .operand_b_i(operand_b),
    .operand_c_i(operand_c), .rf_we_i(rf_we), .lsu_en_i(lsu_en), .lsu_we_i(lsu_we),
    .lsu_size_i(lsu_size), .lsu_sign_ext_i(lsu_sign_ext), .illegal_i(illegal),
    .rd_addr_i(rd_addr), .pc_i(pc_i), .ctrl_xfer_i(ctrl_xfer_o),
    .id_ready_o(id_ready_o), .ex_valid_o(ex_valid_o), .ex_alu_op_o(ex_alu_op_o),
    .ex_operand_a_o(ex_operand_a_o), .ex_operand_b_o(ex_operand_b_o),
    .ex_operand_c_o(ex_operand_c_o), .ex_rf_we_o(ex_rf_we_o), .ex_rd_addr_o(ex_rd_addr_o),
    .ex_lsu_en_o(ex_lsu_en_o), .ex_lsu_we_o(ex_lsu_we_o), .ex_lsu_size_o(ex_lsu_size_o),
    .ex_lsu_sign_ext_o(ex_lsu_sign_ext_o), .ex_branch_o(ex_branch_o),
    .ex_illegal_o(ex_illegal_o), .ex_pc_o(ex_pc_o)
  );

endmodule

// File: verilog/id_ex_reg.sv
/*
 * ID/EX pipeline register
 * Accepts a decoded instruction when EX is ready and the controller
 * neither kills nor halts ID. Holds everything under back-pressure,
 * clears valid when no instruction moves on
 */
`timescale 1ns/1ps

module id_ex_reg (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          instr_valid_i,
  input  logic                          kill_i,
  input  logic                          halt_i,
  input  logic                          ex_ready_i,
  input  id_pkg::alu_op_e               alu_op_i,
  input  logic [id_pkg::XLEN-1:0]       operand_a_i,
  input  logic [id_pkg::XLEN-1:0]       operand_b_i,
  input  logic [id_pkg::XLEN-1:0]       operand_c_i,
  input  logic                          rf_we_i,
  input  logic                          lsu_en_i,
  input  logic                          lsu_we_i,
  input  id_pkg::lsu_size_e             lsu_size_i,
  input  logic                          lsu_sign_ext_i,
  input  logic                          illegal_i,
  input  logic [id_pkg::REG_ADDR_W-1:0] rd_addr_i,
  input  logic [id_pkg::XLEN-1:0]       pc_i,
  input  id_pkg::ctrl_xfer_e            ctrl_xfer_i,
  output logic                          id_ready_o,
  output logic                          ex_valid_o,
  output id_pkg::alu_op_e               ex_alu_op_o,
  output logic [id_pkg::XLEN-1:0]       ex_operand_a_o,
  output logic [id_pkg::XLEN-1:0]       ex_operand_b_o,
  output logic [id_pkg::XLEN-1:0]       ex_operand_c_o,
  output logic                          ex_rf_we_o,
  output logic [id_pkg::REG_ADDR_W-1:0] ex_rd_addr_o,
  output logic                          ex_lsu_en_o,
  output logic                          ex_lsu_we_o,
  output id_pkg::lsu_size_e             ex_lsu_size_o,
  output logic                          ex_lsu_sign_ext_o,
  output logic                          ex_branch_o,
  output logic                          ex_illegal_o,
  output logic [id_pkg::XLEN-1:0]       ex_pc_o
);

  logic accept;

  // Kill drains ID at once, halt freezes it
  assign id_ready_o = kill_i || (ex_ready_i && !halt_i);
  assign accept     = instr_valid_i && !kill_i && !halt_i && ex_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid_o     <= 1'b0;
      ex_alu_op_o    <= id_pkg::ALU_ADD;
      ex_operand_a_o <= '0;
      ex_operand_b_o <= '0;
      ex_operand_c_o <= '0;
      ex_rf_we_o     <= 1'b0;
      ex_lsu_en_o    <= 1'b0;
      ex_branch_o    <= 1'b0;
      ex_illegal_o   <= 1'b0;
    end else if (accept) begin
      ex_valid_o     <= 1'b1;
      ex_alu_op_o    <= alu_op_i;
      ex_operand_a_o <= operand_a_i;
      ex_operand_b_o <= operand_b_i;
      ex_operand_c_o <= operand_c_i;
      ex_rf_we_o     <= rf_we_i;
      ex_lsu_en_o    <= lsu_en_i;
      ex_branch_o    <= (ctrl_xfer_i == id_pkg::XFER_BRANCH);
      ex_illegal_o   <= illegal_i;
    end else if (ex_ready_i) begin
      // bubble into EX, data fields keep their values
      ex_valid_o <= 1'b0;
    end
  end

  // Payload only toggles for the class that uses it
  always_ff @(posedge clk) begin
    if (accept) begin
      ex_pc_o <= pc_i;
      if (rf_we_i) begin
        ex_rd_addr_o <= rd_addr_i;
      end
      if (lsu_en_i) begin
        ex_lsu_we_o       <= lsu_we_i;
        ex_lsu_size_o     <= lsu_size_i;
        ex_lsu_sign_ext_o <= lsu_sign_ext_i;
      end
    end
  end

  // EX stalled means the stage output must not move
  assert property (@(posedge clk) disable iff (!rst_n)
    !ex_ready_i |=> $stable(ex_valid_o) && $stable(ex_operand_a_o) &&
                    $stable(ex_operand_b_o) && $stable(ex_operand_c_o));

endmodule

// File: verilog/operand_select.sv
/*
 * Operand selection and target generation
 * Forwards EX or WB results over register file data, builds
 * operands A, B and C, and computes branch and jump targets
 */
`timescale 1ns/1ps

module operand_select (
  input  logic [id_pkg::XLEN-1:0] pc_i,
  input  logic [id_pkg::XLEN-1:0] rs1_rdata_i,
  input  logic [id_pkg::XLEN-1:0] rs2_rdata_i,
  input  logic [id_pkg::XLEN-1:0] ex_wdata_i,
  input  logic [id_pkg::XLEN-1:0] wb_wdata_i,
  input  id_pkg::fw_sel_e         fw_a_sel_i,
  input  id_pkg::fw_sel_e         fw_b_sel_i,
  input  id_pkg::op_a_sel_e       op_a_sel_i,
  input  id_pkg::op_b_sel_e       op_b_sel_i,
  input  id_pkg::op_c_sel_e       op_c_sel_i,
  input  id_pkg::ctrl_xfer_e      ctrl_xfer_i,
  input  logic [id_pkg::XLEN-1:0] imm_b_i,
  input  logic [id_pkg::XLEN-1:0] imm_i_i,
  input  logic [id_pkg::XLEN-1:0] imm_sb_i,
  input  logic [id_pkg::XLEN-1:0] imm_j_i,
  input  logic [id_pkg::XLEN-1:0] imm_u_i,
  output logic [id_pkg::XLEN-1:0] operand_a_o,
  output logic [id_pkg::XLEN-1:0] operand_b_o,
  output logic [id_pkg::XLEN-1:0] operand_c_o,
  output logic [id_pkg::XLEN-1:0] jmp_target_o
);

  logic [id_pkg::XLEN-1:0] fw_a;
  logic [id_pkg::XLEN-1:0] fw_b;
  logic [id_pkg::XLEN-1:0] branch_tgt;
  logic [id_pkg::XLEN-1:0] jalr_tgt;

  ////////////////////
  // Forwarding
  ////////////////////

  always_comb begin
    case (fw_a_sel_i)
      id_pkg::FW_EX: fw_a = ex_wdata_i;
      id_pkg::FW_WB: fw_a = wb_wdata_i;
      default:       fw_a = rs1_rdata_i;
    endcase
    case (fw_b_sel_i)
      id_pkg::FW_EX: fw_b = ex_wdata_i;
      id_pkg::FW_WB: fw_b = wb_wdata_i;
      default:       fw_b = rs2_rdata_i;
    endcase
  end

  ////////////////////
  // Targets
  ////////////////////

  assign branch_tgt = pc_i + imm_sb_i;
  // jalr target uses the forwarded rs1, LSB forced low
  assign jalr_tgt   = (fw_a + imm_i_i) & ~id_pkg::XLEN'(1);

  assign jmp_target_o = (ctrl_xfer_i == id_pkg::XFER_JALR) ? jalr_tgt : pc_i + imm_j_i;

  ////////////////////
  // Operand muxes
  ////////////////////

  always_comb begin
    case (op_a_sel_i)
      id_pkg::OP_A_PC:   operand_a_o = pc_i;
      id_pkg::OP_A_ZERO: operand_a_o = '0;
      default:           operand_a_o = fw_a;
    endcase
    operand_b_o = (op_b_sel_i == id_pkg::OP_B_IMM) ? imm_b_i : fw_b;
    case (op_c_sel_i)
      id_pkg::OP_C_REG_B:      operand_c_o = fw_b;
      id_pkg::OP_C_BRANCH_TGT: operand_c_o = branch_tgt;
      default:                 operand_c_o = '0;
    endcase

    // Controller only issues the three defined bypass codes
    if (!$isunknown({fw_a_sel_i, fw_b_sel_i})) begin
      assert (fw_a_sel_i inside {id_pkg::FW_RF, id_pkg::FW_EX, id_pkg::FW_WB});
      assert (fw_b_sel_i inside {id_pkg::FW_RF, id_pkg::FW_EX, id_pkg::FW_WB});
    end
    // Zero A only comes with LUI, so decoder and imm_gen must agree on U
    if (op_a_sel_i == id_pkg::OP_A_ZERO) begin
      assert (operand_b_o == imm_u_i);
    end
  end

endmodule

// File: verilog/imm_gen.sv
/*
 * Immediate generator
 * Sign extends the I, S, B and J immediates, builds the U immediate
 * and selects the immediate for operand B
 */
`timescale 1ns/1ps

module imm_gen (
  input  logic [id_pkg::XLEN-1:0] instr_i,
  input  id_pkg::imm_sel_e        imm_sel_i,
  output logic [id_pkg::XLEN-1:0] imm_b_o,
  output logic [id_pkg::XLEN-1:0] imm_i_o,
  output logic [id_pkg::XLEN-1:0] imm_sb_o,
  output logic [id_pkg::XLEN-1:0] imm_j_o,
  output logic [id_pkg::XLEN-1:0] imm_u_o
);

  logic [id_pkg::XLEN-1:0] imm_s;

  // Bit 31 is the sign for every format
  assign imm_i_o  = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s    = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u_o  = {instr_i[31:12], 12'b0};

  // Branch and jump offsets are halfword aligned
  assign imm_sb_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                     instr_i[11:8], 1'b0};
  assign imm_j_o  = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  always_comb begin
    case (imm_sel_i)
      id_pkg::IMM_S:      imm_b_o = imm_s;
      id_pkg::IMM_U:      imm_b_o = imm_u_o;
      id_pkg::IMM_PCINCR: imm_b_o = id_pkg::XLEN'(id_pkg::PC_INCR);
      default:            imm_b_o = imm_i_o;
    endcase
  end

endmodule

// File: verilog/instr_decoder.sv
/*
 * RV32I instruction decoder
 * Maps opcode, funct3 and funct7 onto ALU op, operand and immediate
 * selects, LSU controls and control-transfer type. Unknown encodings
 * raise illegal and drop the register and memory enables
 */
`timescale 1ns/1ps

module instr_decoder (
  input  logic [id_pkg::XLEN-1:0] instr_i,
  input  logic                    deassert_we_i,
  output id_pkg::alu_op_e         alu_op_o,
  output id_pkg::op_a_sel_e       op_a_sel_o,
  output id_pkg::op_b_sel_e       op_b_sel_o,
  output id_pkg::op_c_sel_e       op_c_sel_o,
  output id_pkg::imm_sel_e        imm_sel_o,
  output id_pkg::ctrl_xfer_e      ctrl_xfer_o,
  output logic                    rf_we_o,
  output logic                    lsu_en_o,
  output logic                    lsu_we_o,
  output id_pkg::lsu_size_e       lsu_size_o,
  output logic                    lsu_sign_ext_o,
  output logic                    illegal_o
);

  id_pkg::opcode_e opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;

  assign opcode = id_pkg::opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // funct3 to ALU op for OP and OP-IMM, alt picks SUB or SRA
  function automatic id_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    id_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
      3'b001:  op = id_pkg::ALU_SLL;
      3'b010:  op = id_pkg::ALU_SLT;
      3'b011:  op = id_pkg::ALU_SLTU;
      3'b100:  op = id_pkg::ALU_XOR;
      3'b101:  op = alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
      3'b110:  op = id_pkg::ALU_OR;
      default: op = id_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    logic rf_we_raw;
    logic lsu_en_raw;

    // Defaults describe a register-register ADD with nothing enabled
    rf_we_raw      = 1'b0;
    lsu_en_raw     = 1'b0;
    illegal_o      = 1'b0;
    alu_op_o       = id_pkg::ALU_ADD;
    op_a_sel_o     = id_pkg::OP_A_REG;
    op_b_sel_o     = id_pkg::OP_B_REG;
    op_c_sel_o     = id_pkg::OP_C_ZERO;
    imm_sel_o      = id_pkg::IMM_I;
    ctrl_xfer_o    = id_pkg::XFER_NONE;
    lsu_we_o       = 1'b0;
    lsu_size_o     = id_pkg::lsu_size_e'(funct3[1:0]);
    lsu_sign_ext_o = 1'b0;

    case (opcode)
      id_pkg::OPC_OP: begin
        rf_we_raw = 1'b1;
        alu_op_o  = arith_op(funct3, funct7[5]);
        // Only ADD and SRL have a second encoding
        if (funct7 == 7'h20) begin
          illegal_o = (funct3 != 3'b000) && (funct3 != 3'b101);
        end else begin
          illegal_o = (funct7 != 7'h00);
        end
      end
      id_pkg::OPC_OP_IMM: begin
        rf_we_raw  = 1'b1;
        op_b_sel_o = id_pkg::OP_B_IMM;
        alu_op_o   = arith_op(funct3, (funct3 == 3'b101) && funct7[5]);
        // shift immediates keep a funct7 field
        if (funct3 == 3'b001) begin
          illegal_o = (funct7 != 7'h00);
        end else if (funct3 == 3'b101) begin
          illegal_o = (funct7 != 7'h00) && (funct7 != 7'h20);
        end
      end
      id_pkg::OPC_LUI, id_pkg::OPC_AUIPC: begin
        rf_we_raw  = 1'b1;
        op_a_sel_o = (opcode == id_pkg::OPC_LUI) ? id_pkg::OP_A_ZERO : id_pkg::OP_A_PC;
        op_b_sel_o = id_pkg::OP_B_IMM;
        imm_sel_o  = id_pkg::IMM_U;
      end
      id_pkg::OPC_JAL, id_pkg::OPC_JALR: begin
        // Link value is PC + 4 through the ALU
        rf_we_raw   = 1'b1;
        op_a_sel_o  = id_pkg::OP_A_PC;
        op_b_sel_o  = id_pkg::OP_B_IMM;
        imm_sel_o   = id_pkg::IMM_PCINCR;
        ctrl_xfer_o = (opcode == id_pkg::OPC_JAL) ? id_pkg::XFER_JAL : id_pkg::XFER_JALR;
        illegal_o   = (opcode == id_pkg::OPC_JALR) && (funct3 != 3'b000);
      end
      id_pkg::OPC_BRANCH: begin
        op_c_sel_o  = id_pkg::OP_C_BRANCH_TGT;
        ctrl_xfer_o = id_pkg::XFER_BRANCH;
        case (funct3)
          3'b000:  alu_op_o = id_pkg::ALU_EQ;
          3'b001:  alu_op_o = id_pkg::ALU_NE;
          3'b100:  alu_op_o = id_pkg::ALU_LT;
          3'b101:  alu_op_o = id_pkg::ALU_GE;
          3'b110:  alu_op_o = id_pkg::ALU_LTU;
          3'b111:  alu_op_o = id_pkg::ALU_GEU;
          default: illegal_o = 1'b1;
        endcase
      end
      id_pkg::OPC_LOAD: begin
        // Address is rs1 + I immediate
        rf_we_raw      = 1'b1;
        lsu_en_raw     = 1'b1;
        op_b_sel_o     = id_pkg::OP_B_IMM;
        lsu_sign_ext_o = !funct3[2];
        illegal_o      = (funct3[1:0] == 2'b11) || (funct3[2] && funct3[1]);
      end
      id_pkg::OPC_STORE: begin
        // Store data travels on operand C
        lsu_en_raw = 1'b1;
        lsu_we_o   = 1'b1;
        op_b_sel_o = id_pkg::OP_B_IMM;
        op_c_sel_o = id_pkg::OP_C_REG_B;
        imm_sel_o  = id_pkg::IMM_S;
        illegal_o  = funct3[2] || (funct3[1:0] == 2'b11);
      end
      default: illegal_o = 1'b1;
    endcase

    // Controller squash and illegal encodings both drop the enables
    rf_we_o  = rf_we_raw && !illegal_o && !deassert_we_i;
    lsu_en_o = lsu_en_raw && !illegal_o && !deassert_we_i;
  end

endmodule

// File: verilog/id_pkg.sv
/*
 * Decode stage shared definitions
 * Data and register address widths, register field positions and
 * the encodings used between decoder, operand path and ID/EX register
 */
package id_pkg;

  // Data path and register file sizes
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;

  // Register field positions in the instruction word
  localparam int unsigned RS1_LSB = 15;
  localparam int unsigned RS2_LSB = 20;
  localparam int unsigned RD_LSB  = 7;

  // Link offset, no compressed instructions
  localparam int unsigned PC_INCR = 4;

  // RV32I major opcodes
  typedef enum logic [6:0] {
    OPC_OP     = 7'h33,
    OPC_OP_IMM = 7'h13,
    OPC_LUI    = 7'h37,
    OPC_AUIPC  = 7'h17,
    OPC_JAL    = 7'h6f,
    OPC_JALR   = 7'h67,
    OPC_BRANCH = 7'h63,
    OPC_LOAD   = 7'h03,
    OPC_STORE  = 7'h23
  } opcode_e;

  // Arithmetic ops first, then branch compares
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO} op_a_sel_e;

  typedef enum logic {OP_B_REG, OP_B_IMM} op_b_sel_e;

  typedef enum logic [1:0] {OP_C_REG_B, OP_C_BRANCH_TGT, OP_C_ZERO} op_c_sel_e;

  typedef enum logic [1:0] {IMM_I, IMM_S, IMM_U, IMM_PCINCR} imm_sel_e;

  // Source of a register operand
  typedef enum logic [1:0] {FW_RF, FW_EX, FW_WB} fw_sel_e;

  typedef enum logic [1:0] {XFER_NONE, XFER_JAL, XFER_JALR, XFER_BRANCH} ctrl_xfer_e;

  // Matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {LSU_BYTE, LSU_HALF, LSU_WORD} lsu_size_e;

endpackage
